// File: list.f
+incdir+hdl
hdl/emesh_pkg.sv
hdl/link_pkg.sv
hdl/etx_ifs.sv
hdl/gray_sync.sv
hdl/fifo_async.sv
hdl/etx_packer.sv
hdl/etx_ctrl.sv
hdl/etx_serializer.sv
hdl/etx_top.sv
verif/tb_etx.sv

// File: Makefile
TOP = tb_etx
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_etx.sv
// Testbench for the transmit half of the mesh-to-link bridge
// drives core accesses on wr_clk, rebuilds 14-byte frames seen on
// the link and checks opcode, payload, order, wait and drop counting
// the result is the last line printed when run through the Makefile
`timescale 1ns/1ps

module tb_etx
   import emesh_pkg::*;
   import link_pkg::*;
();

   localparam logic [31:0] LFSR_SEED  = 32'd67309;
   localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;  // x^32+x^22+x^2+x+1
   localparam int          WAIT_LIMIT = 400;            // base cycles per wait loop
   localparam int          NUM_VEC    = 6;

   typedef struct {
      emesh_packet_t pkt;
      frame_op_t     op;     // header byte the frame must carry
   } vector_t;

   logic          wr_clk;
   logic          rd_clk;
   logic          rst;
   logic          access;
   logic          write;
   datamode_t     datamode;
   logic [3:0]    ctrlmode;
   logic [31:0]   dstaddr;
   logic [31:0]   data;
   logic [31:0]   srcaddr;
   logic          wr_wait;
   logic [7:0]    drop_count;
   logic          tx_enable;
   logic          tx_frame;
   logic [7:0]    tx_data;

   vector_t       vectors [NUM_VEC];
   emesh_packet_t sent_q [$];     // packets in send order
   logic [111:0]  frame_q [$];    // header, payload, pad
   int            len_q [$];      // bytes per collected frame
   logic [111:0]  frame_buf;
   int            frame_len;
   int            frame_total;
   logic [31:0]   lfsr;
   int            error_count;
   int            checks_done;
   int            tests_done;

   etx_top DUT (
      .wr_clk, .rd_clk, .rst, .access, .write, .datamode, .ctrlmode,
      .dstaddr, .data, .srcaddr, .wr_wait, .drop_count,
      .tx_enable, .tx_frame, .tx_data
   );

   initial begin
      rd_clk = 1'b0;
      forever #4 rd_clk = ~rd_clk;  // 8 ns link clock
   end

   initial begin
      wr_clk = 1'b0;
      forever #6 wr_clk = ~wr_clk;  // 12 ns core clock
   end

   // hard stop well past the longest legal run
   initial begin
      #200000;
      $display("simulation ran past its time limit");
      $display("TB FAILED");
      $finish;
   end

   // frame collector samples away from the rising edge
   always @(negedge rd_clk) begin
      if (tx_frame === 1'b1) begin
         frame_buf = {frame_buf[103:0], tx_data};  // header ends up on top
         frame_len++;
      end else if (frame_len != 0) begin
         frame_q.push_back(frame_buf);
         len_q.push_back(frame_len);
         frame_total++;
         frame_len = 0;
      end
   end

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic emesh_packet_t random_packet();
      emesh_packet_t p;
      logic [31:0]   r;
      r          = rand_bits(1);
      p.write    = r[0];
      r          = rand_bits(2);
      p.datamode = datamode_t'(r[1:0]);
      r          = rand_bits(4);
      p.ctrlmode = r[3:0];
      p.dstaddr  = rand_bits(32);
      p.data     = rand_bits(32);
      p.srcaddr  = rand_bits(32);
      return p;
   endfunction

   function automatic emesh_packet_t make_packet(input logic w, input datamode_t dm,
      input logic [3:0] cm, input logic [31:0] dst, input logic [31:0] dat,
      input logic [31:0] src);
      return '{write: w, datamode: dm, ctrlmode: cm, dstaddr: dst, data: dat, srcaddr: src};
   endfunction

   // header follows the write bit
   function automatic frame_op_t expected_op(input emesh_packet_t p);
      return p.write ? OP_WRITE : OP_READ;
   endfunction

   task automatic init_vectors();
      vectors[0] = '{make_packet(1'b1, DM_WORD, 4'h0, 32'h8000_0000, 32'hdead_beef,
                                 32'h0000_0040), OP_WRITE};
      vectors[1] = '{make_packet(1'b0, DM_WORD, 4'h0, 32'h8000_0004, 32'h0000_0000,
                                 32'h0810_0000), OP_READ};
      vectors[2] = '{make_packet(1'b1, DM_BYTE, 4'hf, 32'hffff_ffff, 32'h0000_00a5,
                                 32'h1234_5678), OP_WRITE};
      vectors[3] = '{make_packet(1'b0, DM_DOUBLE, 4'h5, 32'h0000_0000, 32'hffff_ffff,
                                 32'hffff_ffff), OP_READ};  // all-ones fields
      vectors[4] = '{make_packet(1'b1, DM_HALF, 4'ha, 32'h5555_5555, 32'haaaa_aaaa,
                                 32'h0f0f_0f0f), OP_WRITE};
      vectors[5] = '{make_packet(1'b1, DM_DOUBLE, 4'h1, 32'h0000_0001, 32'h8000_0000,
                                 32'h0000_0000), OP_WRITE};
   endtask

   task automatic check_packet(input string what, input emesh_packet_t got,
                               input emesh_packet_t exp);
      checks_done++;
      if (got !== exp) begin
         error_count++;
         $display("FAIL t=%0t %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_opcode(input string what, input frame_op_t got, input frame_op_t exp);
      checks_done++;
      if (got !== exp) begin
         error_count++;
         $display("FAIL t=%0t %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input string what, input logic [7:0] got, input logic [7:0] exp);
      checks_done++;
      if (got !== exp) begin
         error_count++;
         $display("FAIL t=%0t %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic wait_frames(input int n, input string what);
      int cycles;
      cycles = 0;
      while (frame_q.size() < n && cycles < WAIT_LIMIT + 40 * n) begin
         @(posedge rd_clk);
         cycles++;
      end
      if (frame_q.size() < n) begin
         error_count++;
         $display("timeout while waiting for %s, %0d of %0d frames", what, frame_q.size(), n);
      end
   endtask

   // pops one collected frame and splits it into its fields
   task automatic verify_frame(input emesh_packet_t exp, input frame_op_t op);
      logic [111:0] f;
      int           len;
      if (frame_q.size() == 0) begin
         error_count++;
         $display("no collected frame left to compare");
         return;
      end
      f   = frame_q.pop_front();
      len = len_q.pop_front();
      check_count("frame length", 8'(len), 8'd14);
      check_opcode("header opcode", frame_op_t'(f[111:104]), op);
      check_packet("payload", emesh_packet_t'(f[103:1]), exp);
      check_count("pad bit", {7'b0, f[0]}, 8'd0);
   endtask

   task automatic send_packet(input emesh_packet_t p);
      @(posedge wr_clk);
      #1;
      access   = 1'b1;
      write    = p.write;
      datamode = p.datamode;
      ctrlmode = p.ctrlmode;
      dstaddr  = p.dstaddr;
      data     = p.data;
      srcaddr  = p.srcaddr;
   endtask

   task automatic idle_core();
      @(posedge wr_clk);
      #1;
      access = 1'b0;
   endtask

   // holds off while wait is up
   task automatic send_when_ready(input emesh_packet_t p);
      int cycles;
      cycles = 0;
      while (wr_wait === 1'b1 && cycles < WAIT_LIMIT) begin
         idle_core();
         cycles++;
      end
      if (wr_wait === 1'b1) begin
         error_count++;
         $display("timeout while waiting for wait to fall before a send");
      end
      send_packet(p);
   endtask

   task automatic wait_for_wait(input logic level);
      int cycles;
      cycles = 0;
      while (wr_wait !== level && cycles < WAIT_LIMIT) begin
         @(posedge wr_clk);
         #1;
         cycles++;
      end
      if (wr_wait !== level) begin
         error_count++;
         $display("timeout while waiting for wait to reach %0b", level);
      end
   endtask

   task automatic set_tx_enable(input logic v);
      @(posedge wr_clk);
      #1;
      tx_enable = v;
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_done++;
      if (error_count == err_before) $display("test %0d %s: ok", tests_done, name);
      else $display("test %0d %s: %0d errors", tests_done, name, error_count - err_before);
   endtask

   initial begin
      emesh_packet_t p;
      int            err0;
      int            total0;
      rst = 1'b1;
      access = 1'b0;
      write = 1'b0;
      datamode = DM_BYTE;
      ctrlmode = 4'h0;
      dstaddr = 32'h0;
      data = 32'h0;
      srcaddr = 32'h0;
      tx_enable = 1'b0;
      frame_buf = '0;
      frame_len = 0;
      frame_total = 0;
      lfsr = LFSR_SEED;
      error_count = 0;
      checks_done = 0;
      tests_done = 0;
      init_vectors();
      repeat (4) @(posedge wr_clk);
      #1;
      rst = 1'b0;

      // outputs quiet after reset, link enabled with nothing queued
      err0 = error_count;
      check_count("tx_frame after reset", {7'b0, tx_frame}, 8'd0);
      check_count("wait after reset", {7'b0, wr_wait}, 8'd0);
      check_count("drop_count after reset", drop_count, 8'd0);
      set_tx_enable(1'b1);
      repeat (40) @(posedge rd_clk);
      check_count("frames while idle", 8'(frame_total), 8'd0);
      report_test("reset state", err0);

      // table entries one frame at a time
      err0 = error_count;
      for (int i = 0; i < NUM_VEC; i++) begin
         send_packet(vectors[i].pkt);
         idle_core();
         wait_frames(1, "table frame");
         verify_frame(vectors[i].pkt, vectors[i].op);
      end
      report_test("table frames", err0);

      // lfsr burst with wait honoured
      err0 = error_count;
      for (int i = 0; i < 20; i++) begin
         p = random_packet();
         send_when_ready(p);
         sent_q.push_back(p);
      end
      idle_core();
      wait_frames(20, "burst frames");
      for (int i = 0; i < 20; i++) begin
         p = sent_q.pop_front();
         verify_frame(p, expected_op(p));
      end
      check_count("drop_count after burst", drop_count, 8'd0);
      report_test("burst of 20", err0);

      // 36 writes into 32 entries with the link stalled
      err0 = error_count;
      set_tx_enable(1'b0);
      total0 = frame_total;
      for (int i = 0; i < 36; i++) begin
         p = random_packet();
         send_packet(p);
         sent_q.push_back(p);  // last 4 expected to drop
         if (i == 14) begin
            idle_core();
            repeat (4) @(posedge wr_clk);
            #1;
            check_count("wait at 15 entries", {7'b0, wr_wait}, 8'd0);
         end
         if (i == 15) begin
            idle_core();
            wait_for_wait(1'b1);
         end
      end
      idle_core();
      repeat (3) @(posedge wr_clk);  // strobe, write, count
      #1;
      check_count("drop_count when full", drop_count, 8'd4);
      check_count("frames while disabled", 8'(frame_total - total0), 8'd0);
      report_test("fill and drop", err0);

      // drain the 32 accepted packets
      err0 = error_count;
      set_tx_enable(1'b1);
      wait_frames(32, "drained frames");
      for (int i = 0; i < 32; i++) begin
         p = sent_q.pop_front();
         verify_frame(p, expected_op(p));
      end
      wait_for_wait(1'b0);
      repeat (40) @(posedge rd_clk);
      check_count("frames after drain", 8'(frame_total - total0), 8'd32);
      check_count("extra frames queued", 8'(frame_q.size()), 8'd0);
      report_test("drain", err0);

      $display("tests=%0d checks=%0d errors=%0d", tests_done, checks_done, error_count);
      if (error_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: hdl/etx_top.sv
// Transmit half of the mesh-to-link bridge
// core side: access strobe with fields, wr_wait and drop_count back
// link side: tx_enable in, 14-byte frames out on tx_data with tx_frame
// hold rst for at least 4 cycles of both clocks
`timescale 1ns/1ps
`include "emesh_defines.svh"

module etx_top
   import emesh_pkg::*;
(
   input  logic        wr_clk,      // core clock
   input  logic        rd_clk,      // link clock
   input  logic        rst,
   input  logic        access,
   input  logic        write,
   input  datamode_t   datamode,
   input  logic [3:0]  ctrlmode,
   input  logic [31:0] dstaddr,
   input  logic [31:0] data,
   input  logic [31:0] srcaddr,
   output logic        wr_wait,
   output logic [7:0]  drop_count,
   input  logic        tx_enable,
   output logic        tx_frame,
   output logic [7:0]  tx_data
);

   logic          rd_en;
   emesh_packet_t rd_data;
   logic          rd_empty;

   fifo_wr_if wr_if ();
   ser_if     s_if ();

   etx_packer u_packer (
      .wr_clk, .rst, .access, .write, .datamode, .ctrlmode,
      .dstaddr, .data, .srcaddr,
      .fifo       (wr_if.producer),
      .wr_wait, .drop_count
   );

   fifo_async #(.AW(`EMESH_FIFO_AW), .PROGFULL(`EMESH_PROGFULL)) u_fifo (
      .wr_clk, .rd_clk, .rst,
      .wr         (wr_if.fifo),
      .rd_en, .rd_data, .rd_empty
   );

   etx_ctrl u_ctrl (
      .rd_clk, .rst, .tx_enable,
      .rd_en, .rd_data, .rd_empty,
      .ser        (s_if.ctrl)
   );

   etx_serializer u_ser (
      .rd_clk, .rst,
      .ser        (s_if.ser),
      .tx_frame, .tx_data
   );

endmodule

// File: hdl/etx_serializer.sv
// Byte serializer for link frames
// on load captures header, packet and one zero pad bit into a
// 112-bit shift register and sends it 8 bits per cycle, MSB first
// tx_frame covers exactly the 14 bytes, last marks byte 13
`timescale 1ns/1ps

module etx_serializer (
   input  logic       rd_clk,
   input  logic       rst,
   ser_if.ser         ser,
   output logic       tx_frame,
   output logic [7:0] tx_data
);

   localparam int          SHIFT_W   = 112;    // 8 + 103 + 1 pad
   localparam logic [3:0]  LAST_BYTE = 4'd13;

   logic [SHIFT_W-1:0] shreg;     // payload, no reset
   logic [3:0]         byte_cnt;  // byte index within frame

   always_ff @(posedge rd_clk) begin
      if (rst) begin
         tx_frame <= 1'b0;
         byte_cnt <= 4'd0;
      end else if (ser.load) begin
         tx_frame <= 1'b1;        // header goes out next cycle
         byte_cnt <= 4'd0;
      end else if (tx_frame) begin
         byte_cnt <= byte_cnt + 4'd1;
         if (ser.last) tx_frame <= 1'b0;
      end
   end

   always_ff @(posedge rd_clk) begin
      if (ser.load) begin
         shreg <= {ser.opcode, ser.payload, 1'b0};
      end else if (tx_frame) begin
         shreg <= {shreg[SHIFT_W-9:0], 8'h00};  // next byte to top
      end
   end

   assign tx_data  = shreg[SHIFT_W-1:SHIFT_W-8];
   assign ser.last = tx_frame && (byte_cnt == LAST_BYTE);

endmodule

// File: hdl/etx_ctrl.sv
// Link-side transmit control
// pops one packet when the FIFO has data and tx_enable is set,
// picks the header opcode from the write bit and loads the serializer
// then waits for the last byte before looking again
// a frame already loaded always finishes, tx_enable only gates new pops
`timescale 1ns/1ps

module etx_ctrl
   import emesh_pkg::*;
   import link_pkg::*;
(
   input  logic          rd_clk,
   input  logic          rst,
   input  logic          tx_enable,
   output logic          rd_en,
   input  emesh_packet_t rd_data,    // valid the cycle after rd_en
   input  logic          rd_empty,
   ser_if.ctrl           ser
);

   tx_state_t state;
   tx_state_t state_nxt;

   always_ff @(posedge rd_clk) begin
      if (rst) state <= IDLE;
      else     state <= state_nxt;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (!rd_empty && tx_enable) state_nxt = POP;
         end
         POP:  state_nxt = LOAD;   // fifo output registers now
         LOAD: state_nxt = SEND;
         SEND: begin
            if (ser.last) state_nxt = IDLE;  // gap of 3 cycles min
         end
         default: state_nxt = IDLE;
      endcase
   end

   assign rd_en = (state == POP);

   // rd_data holds the popped packet during LOAD
   assign ser.load    = (state == LOAD);
   assign ser.payload = rd_data;
   assign ser.opcode  = rd_data.write ? OP_WRITE : OP_READ;

   // serializer takes 14 cycles per frame, last on the final one
   property p_load_spacing;
      @(posedge rd_clk) disable iff (rst)
         ser.load |=> (!ser.load) [*13] ##1 (ser.last && !ser.load);
   endproperty

   a_load_spacing: assert property (p_load_spacing)
      else $error("load while serializer busy or frame length wrong");

endmodule

// File: hdl/etx_packer.sv
// Core-side packer for the transmit bridge
// registers one access per strobe into a packet and writes it to
// the async FIFO the following cycle
// accesses that find the FIFO full are dropped and counted
// wr_wait is advisory back-pressure from programmable full
`timescale 1ns/1ps
`include "emesh_defines.svh"

module etx_packer
   import emesh_pkg::*;
(
   input  logic        wr_clk,
   input  logic        rst,
   input  logic        access,      // one-cycle strobe
   input  logic        write,
   input  datamode_t   datamode,
   input  logic [3:0]  ctrlmode,
   input  logic [31:0] dstaddr,
   input  logic [31:0] data,
   input  logic [31:0] srcaddr,
   fifo_wr_if.producer fifo,
   output logic        wr_wait,     // registered progfull
   output logic [7:0]  drop_count   // saturates at 255
);

   logic [`EMESH_PACKET_W-1:0] pkt_q;  // packed in emesh_packet_t order
   logic                       access_q;
   logic                       drop;

   // wr_full already covers last cycle's write
   assign fifo.wr_en   = access_q && !fifo.wr_full;
   assign fifo.wr_data = emesh_packet_t'(pkt_q);
   assign drop         = access_q && fifo.wr_full;

   always_ff @(posedge wr_clk) begin
      if (access) pkt_q <= {write, datamode, ctrlmode, dstaddr, data, srcaddr};
   end

   always_ff @(posedge wr_clk) begin
      if (rst) begin
         access_q   <= 1'b0;
         wr_wait    <= 1'b0;
         drop_count <= 8'd0;
      end else begin
         access_q <= access;           // write lands one cycle later
         wr_wait  <= fifo.wr_progfull;
         if (drop && (drop_count != 8'hFF)) begin
            drop_count <= drop_count + 8'd1;
         end
      end
   end

endmodule

// File: hdl/fifo_async.sv
// Dual-clock FIFO between core and link domains
// write port comes in on fifo_wr_if, read port is plain ports
// full, progfull and empty are registered and see the local
// pointer update of the same cycle; the far pointer arrives late
// so flags stay conservative
// rd_data is registered, valid the cycle after rd_en
`timescale 1ns/1ps
`include "emesh_defines.svh"

module fifo_async
   import emesh_pkg::*;
#(
   parameter int AW       = `EMESH_FIFO_AW,
   parameter int PROGFULL = `EMESH_PROGFULL
) (
   input  logic          wr_clk,
   input  logic          rd_clk,
   input  logic          rst,       // held on both clocks
   fifo_wr_if.fifo       wr,
   input  logic          rd_en,
   output emesh_packet_t rd_data,
   output logic          rd_empty
);

   localparam int DEPTH = 1 << AW;

   emesh_packet_t mem [DEPTH];  // payload storage, no reset

   logic [AW:0] wr_bin;         // extra msb is the wrap bit
   logic [AW:0] wr_bin_nxt;
   logic [AW:0] rd_bin;
   logic [AW:0] rd_bin_nxt;
   logic [AW:0] rd_gray_sync;   // read ptr seen on write side
   logic [AW:0] wr_gray_sync;   // write ptr seen on read side
   logic [AW:0] wr_level_nxt;
   logic        wr_push;
   logic        rd_pop;

   function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--) b[i] = b[i+1] ^ g[i];
      return b;
   endfunction

   gray_sync #(.width(AW + 1)) u_wr2rd (
      .clk           (rd_clk),
      .rst           (rst),
      .bin_ptr       (wr_bin),
      .gray_sync_ptr (wr_gray_sync)
   );

   gray_sync #(.width(AW + 1)) u_rd2wr (
      .clk           (wr_clk),
      .rst           (rst),
      .bin_ptr       (rd_bin),
      .gray_sync_ptr (rd_gray_sync)
   );

   // write side
   assign wr_push      = wr.wr_en && !wr.wr_full;
   assign wr_bin_nxt   = wr_bin + {{AW{1'b0}}, wr_push};
   assign wr_level_nxt = wr_bin_nxt - gray2bin(rd_gray_sync);  // wraps cleanly

   always_ff @(posedge wr_clk) begin
      if (rst) begin
         wr_bin         <= '0;
         wr.wr_full     <= 1'b0;
         wr.wr_progfull <= 1'b0;
      end else begin
         wr_bin         <= wr_bin_nxt;
         wr.wr_full     <= (wr_level_nxt == DEPTH);
         wr.wr_progfull <= (wr_level_nxt >= PROGFULL);
      end
   end

   always_ff @(posedge wr_clk) begin
      if (wr_push) mem[wr_bin[AW-1:0]] <= wr.wr_data;
   end

   // read side
   assign rd_pop     = rd_en && !rd_empty;
   assign rd_bin_nxt = rd_bin + {{AW{1'b0}}, rd_pop};

   always_ff @(posedge rd_clk) begin
      if (rst) begin
         rd_bin   <= '0;
         rd_empty <= 1'b1;
      end else begin
         rd_bin   <= rd_bin_nxt;
         rd_empty <= (rd_bin_nxt == gray2bin(wr_gray_sync));
      end
   end

   always_ff @(posedge rd_clk) begin
      if (rd_pop) rd_data <= mem[rd_bin[AW-1:0]];  // registered output
   end

   // packer must see full before strobing
   a_no_write_full: assert property (@(posedge wr_clk) disable iff (rst)
      !(wr.wr_en && wr.wr_full))
      else $error("fifo write while full");

   // ctrl must only pop when data is there
   a_no_read_empty: assert property (@(posedge rd_clk) disable iff (rst)
      !(rd_en && rd_empty))
      else $error("fifo read while empty");

endmodule

// File: hdl/gray_sync.sv
// Pointer crossing for the async FIFO
// takes a binary pointer from the far clock domain, gray codes it
// and passes it through two flops clocked by clk
// one instance per direction
`timescale 1ns/1ps

module gray_sync #(
   parameter int width = 6   // address width plus wrap bit
) (
   input  logic             clk,           // destination clock
   input  logic             rst,
   input  logic [width-1:0] bin_ptr,       // flop output in source domain
   output logic [width-1:0] gray_sync_ptr
);

   logic [width-1:0] gray;  // one bit changes per increment
   logic [width-1:0] meta;  // first stage, may go metastable

   assign gray = bin_ptr ^ (bin_ptr >> 1);

   // two-flop synchronizer
   always_ff @(posedge clk) begin
      if (rst) begin
         meta          <= '0;
         gray_sync_ptr <= '0;
      end else begin
         meta          <= gray;
         gray_sync_ptr <= meta;  // safe to use from here on
      end
   end

endmodule

// File: hdl/etx_ifs.sv
// Interfaces used inside the transmit bridge
// fifo_wr_if carries the core-clock write port of the async FIFO
// ser_if carries the link-clock handoff from control FSM to serializer
`timescale 1ns/1ps

// core clock domain
interface fifo_wr_if
   import emesh_pkg::*;
();
   logic          wr_en;        // one-cycle strobe, never while full
   emesh_packet_t wr_data;
   logic          wr_full;      // registered, includes this cycle's write
   logic          wr_progfull;  // level reached EMESH_PROGFULL

   modport producer (output wr_en, output wr_data, input wr_full, input wr_progfull);
   modport fifo (input wr_en, input wr_data, output wr_full, output wr_progfull);
endinterface

// link clock domain
interface ser_if
   import emesh_pkg::*;
   import link_pkg::*;
();
   logic          load;     // one-cycle strobe, serializer idle only
   frame_op_t     opcode;   // header byte
   emesh_packet_t payload;
   logic          last;     // high during final byte of frame

   modport ctrl (output load, output opcode, output payload, input last);
   modport ser (input load, input opcode, input payload, output last);
endinterface

// File: hdl/link_pkg.sv
// Link-side types for the transmit bridge
// FSM states of the transmit control and the frame header opcodes
package link_pkg;

   // transmit control FSM
   typedef enum logic [1:0] {
      IDLE = 2'd0,  // waiting for data and enable
      POP  = 2'd1,  // fifo read strobe
      LOAD = 2'd2,  // rd_data valid, hand to serializer
      SEND = 2'd3   // frame on the wire
   } tx_state_t;

   // first byte of each frame
   typedef enum logic [7:0] {
      OP_WRITE = 8'h81,
      OP_READ  = 8'h82
   } frame_op_t;

endpackage

// File: hdl/emesh_pkg.sv
// Mesh-side types for the transmit bridge
// the packet struct is the payload carried through the async FIFO
// and sent MSB first on the link after the header byte
package emesh_pkg;

   // access size
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,
      DM_HALF   = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } datamode_t;

   // 103 bits, write bit on top
   typedef struct packed {
      logic        write;     // 1 = write, 0 = read request
      datamode_t   datamode;
      logic [3:0]  ctrlmode;  // passed through untouched
      logic [31:0] dstaddr;
      logic [31:0] data;
      logic [31:0] srcaddr;   // return address for reads
   } emesh_packet_t;

endpackage

// File: hdl/emesh_defines.svh
// Sizing macros for the mesh transmit bridge
// include where FIFO geometry or packet width is needed
// widths and types of the packet itself live in emesh_pkg

`ifndef EMESH_DEFINES_SVH
`define EMESH_DEFINES_SVH

// async FIFO address width, 32 entries
`define EMESH_FIFO_AW 5

// flat width of one mesh packet
`define EMESH_PACKET_W 103

// occupancy where core-side wait rises
`define EMESH_PROGFULL 16

`endif
